// ==== common/amo_pkg.sv ====
/*
 * Atomic memory operation adapter package.
 * Word, address and tag widths, opcode and command enums, and the
 * request, command, memory and response structs shared by all blocks.
 */
package amo_pkg;

    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned ADDR_WIDTH     = 16;
    localparam int unsigned ID_WIDTH       = 4;
    localparam int unsigned FIFO_DEPTH     = 4;
    // Derived FIFO widths
    localparam int unsigned FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ID_WIDTH-1:0]   id_t;

    // Returned on every invalid request
    localparam data_t ERR_DATA = '1;

    // Codes 9 to 15 are reserved
    typedef enum logic [3:0] {
        AMO_SWAP = 4'd0,
        AMO_ADD  = 4'd1,
        AMO_CLR  = 4'd2,
        AMO_EOR  = 4'd3,
        AMO_SET  = 4'd4,
        AMO_SMAX = 4'd5,
        AMO_SMIN = 4'd6,
        AMO_UMAX = 4'd7,
        AMO_UMIN = 4'd8
    } amo_op_e;

    typedef enum logic {
        KIND_LOAD  = 1'b0,
        KIND_STORE = 1'b1
    } amo_kind_e;

    typedef enum logic [1:0] {
        CMD_LOAD    = 2'd0,
        CMD_STORE   = 2'd1,
        CMD_INVALID = 2'd2
    } cmd_kind_e;

    typedef struct packed {
        id_t       id;
        amo_kind_e kind;
        amo_op_e   op;
        addr_t     addr;
        data_t     operand;
    } amo_req_t;

    typedef struct packed {
        id_t       id;
        cmd_kind_e cmd_kind;
        amo_op_e   op;
        addr_t     addr;
        data_t     operand;
    } amo_cmd_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        id_t   id;
        logic  err;
        data_t data;
    } amo_rsp_t;

endpackage

// ==== hw/amo_engine/amo_alu.sv ====
/*
 * Atomic ALU. Computes the new memory word from the old word and
 * the request operand for the nine supported opcodes.
 */
module amo_alu import amo_pkg::*; (
    input  amo_op_e op_i,
    input  data_t   old_i,
    input  data_t   operand_i,
    output data_t   result_o
);

    logic signed_lt;
    logic unsigned_lt;

    // Old word compared against the operand
    assign signed_lt   = ($signed(old_i) < $signed(operand_i));
    assign unsigned_lt = (old_i < operand_i);

    always_comb begin
        case (op_i)
            AMO_SWAP: result_o = operand_i;
            AMO_ADD:  result_o = old_i + operand_i;
            AMO_CLR:  result_o = old_i & ~operand_i;
            AMO_EOR:  result_o = old_i ^ operand_i;
            AMO_SET:  result_o = old_i | operand_i;
            AMO_SMAX: result_o = signed_lt ? operand_i : old_i;
            AMO_SMIN: result_o = signed_lt ? old_i : operand_i;
            AMO_UMAX: result_o = unsigned_lt ? operand_i : old_i;
            AMO_UMIN: result_o = unsigned_lt ? old_i : operand_i;
            // Reserved codes never reach a write
            default:  result_o = old_i;
        endcase
    end

endmodule

// ==== hw/amo_engine/amo_engine.sv ====
/*
 * Atomic execution engine. Runs one read-modify-write at a time:
 * read request, wait for data, write back the ALU result, respond.
 * Invalid commands skip memory and get an error response.
 */
module amo_engine import amo_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    input  amo_cmd_t cmd_i,
    output logic     mem_req_valid_o,
    input  logic     mem_req_ready_i,
    output mem_req_t mem_req_o,
    input  logic     mem_rvalid_i,
    input  data_t    mem_rdata_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output amo_rsp_t rsp_o
);

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_WAIT,
        WR_REQ,
        RSP
    } state_e;

    state_e   state_q;
    state_e   state_d;
    amo_cmd_t cmd_q;
    data_t    old_q;
    data_t    alu_result;

    assign cmd_ready_o = (state_q == IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (cmd_valid_i) begin
                    state_d = (cmd_i.cmd_kind == CMD_INVALID) ? RSP : RD_REQ;
                end
            end
            RD_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = WR_REQ;
                end
            end
            WR_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = RSP;
                end
            end
            RSP: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command and old word stay stable for the whole sequence
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
        if ((state_q == RD_WAIT) && mem_rvalid_i) begin
            old_q <= mem_rdata_i;
        end
    end

    amo_alu u_alu (
        .op_i      (cmd_q.op),
        .old_i     (old_q),
        .operand_i (cmd_q.operand),
        .result_o  (alu_result)
    );

    assign mem_req_valid_o = (state_q == RD_REQ) || (state_q == WR_REQ);

    always_comb begin
        mem_req_o.we    = (state_q == WR_REQ);
        mem_req_o.addr  = cmd_q.addr;
        mem_req_o.wdata = alu_result;
    end

    assign rsp_valid_o = (state_q == RSP);

    // Load returns the old word, store returns zero
    always_comb begin
        rsp_o.id   = cmd_q.id;
        rsp_o.err  = 1'b0;
        rsp_o.data = '0;
        case (cmd_q.cmd_kind)
            CMD_LOAD: begin
                rsp_o.data = old_q;
            end
            CMD_INVALID: begin
                rsp_o.err  = 1'b1;
                rsp_o.data = ERR_DATA;
            end
            default: begin
                rsp_o.data = '0;
            end
        endcase
    end

endmodule

// ==== hw/amo_decoder.sv ====
/*
 * Request decoder. Classifies each atomic request as load, store or
 * invalid and holds the result in a single valid/ready output register.
 */
module amo_decoder import amo_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  amo_req_t req_i,
    output logic     cmd_valid_o,
    input  logic     cmd_ready_i,
    output amo_cmd_t cmd_o
);

    logic     cmd_valid_q;
    amo_cmd_t cmd_q;
    amo_cmd_t dec_cmd;
    logic     reserved_op;
    logic     store_swap;
    logic     misaligned;

    assign reserved_op = (req_i.op > AMO_UMIN);
    assign store_swap  = (req_i.kind == KIND_STORE) && (req_i.op == AMO_SWAP);
    assign misaligned  = |req_i.addr[1:0];

    always_comb begin
        dec_cmd.id      = req_i.id;
        dec_cmd.op      = req_i.op;
        dec_cmd.addr    = req_i.addr;
        dec_cmd.operand = req_i.operand;
        if (reserved_op || store_swap || misaligned) begin
            dec_cmd.cmd_kind = CMD_INVALID;
        end else if (req_i.kind == KIND_STORE) begin
            dec_cmd.cmd_kind = CMD_STORE;
        end else begin
            dec_cmd.cmd_kind = CMD_LOAD;
        end
    end

    // Register is free when empty or being drained this cycle
    assign req_ready_o = !cmd_valid_q || cmd_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            cmd_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            cmd_q <= dec_cmd;
        end
    end

    assign cmd_valid_o = cmd_valid_q;
    assign cmd_o       = cmd_q;

endmodule

// ==== hw/amo_req_fifo.sv ====
/*
 * Command FIFO between decoder and engine.
 * Circular buffer with registered output, no fall-through.
 */
module amo_req_fifo import amo_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  amo_cmd_t push_cmd_i,
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output amo_cmd_t pop_cmd_o
);

    amo_cmd_t                  mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_CNT_WIDTH-1:0] count_q;
    logic                      push;
    logic                      pop;

    assign push_ready_o = (count_q != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_cmd_i;
        end
    end

    assign pop_cmd_o = mem_q[rd_ptr_q];

endmodule

// ==== hw/amo_adapter.sv ====
/*
 * Atomic memory operation adapter, top level.
 * Decoder, command FIFO and execution engine in a chain.
 */
module amo_adapter import amo_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  amo_req_t req_i,
    output logic     mem_req_valid_o,
    input  logic     mem_req_ready_i,
    output mem_req_t mem_req_o,
    input  logic     mem_rvalid_i,
    input  data_t    mem_rdata_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output amo_rsp_t rsp_o
);

    logic     cmd_valid;
    logic     cmd_ready;
    amo_cmd_t cmd;
    logic     pop_valid;
    logic     pop_ready;
    amo_cmd_t pop_cmd;

    amo_decoder u_decoder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .cmd_valid_o (cmd_valid),
        .cmd_ready_i (cmd_ready),
        .cmd_o       (cmd)
    );

    amo_req_fifo u_fifo (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_valid_i (cmd_valid),
        .push_ready_o (cmd_ready),
        .push_cmd_i   (cmd),
        .pop_valid_o  (pop_valid),
        .pop_ready_i  (pop_ready),
        .pop_cmd_o    (pop_cmd)
    );

    amo_engine u_engine (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cmd_valid_i     (pop_valid),
        .cmd_ready_o     (pop_ready),
        .cmd_i           (pop_cmd),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_o           (rsp_o)
    );

endmodule

// ==== tb/amo_adapter_properties.sv ====
/*
 * Handshake properties of the atomic adapter, bound to its top level.
 */
module amo_adapter_properties
    import amo_pkg::*;
(
    input logic     clk_i,
    input logic     rst_ni,
    input logic     mem_req_valid_i,
    input logic     mem_req_ready_i,
    input mem_req_t mem_req_i,
    input logic     rsp_valid_i,
    input logic     rsp_ready_i,
    input amo_rsp_t rsp_i
);

    // A stalled memory request keeps valid and payload
    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_i && !mem_req_ready_i
        |=> mem_req_valid_i && (mem_req_i === $past(mem_req_i)))
    else $error("memory request dropped or changed before it was accepted");

    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i && !rsp_ready_i
        |=> rsp_valid_i && (rsp_i === $past(rsp_i)))
    else $error("response dropped or changed before it was accepted");

    // Engine is idle on the memory side while a response waits
    no_mem_during_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i |-> !mem_req_valid_i)
    else $error("memory request issued while a response is pending");

endmodule

bind amo_adapter amo_adapter_properties u_properties (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_i       (mem_req_o),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_i           (rsp_o)
);

// ==== tb/amo_adapter_tb.sv ====
/*
 * Testbench for the atomic memory operation adapter. Random requests
 * are checked against a sequential reference model while a memory
 * model and the response side stall the DUT at random.
 */
module amo_adapter_tb
    import amo_pkg::*;
();

    localparam int N_SAME    = 60;
    localparam int N_INVALID = 40;
    localparam int N_RANDOM  = 200;
    localparam int N_TOTAL   = N_SAME + N_INVALID + N_RANDOM;

    logic     clk_i = 1'b0;
    logic     rst_ni = 1'b0;
    logic     req_valid_i = 1'b0;
    logic     req_ready_o;
    amo_req_t req_i = '0;
    logic     mem_req_valid_o;
    logic     mem_req_ready_i = 1'b0;
    mem_req_t mem_req_o;
    logic     mem_rvalid_i = 1'b0;
    data_t    mem_rdata_i = '0;
    logic     rsp_valid_o;
    logic     rsp_ready_i = 1'b0;
    amo_rsp_t rsp_o;

    integer   seed = 57491;
    int       err_count = 0;
    int       n_rsp = 0;
    int       rd_delay = 0;
    string    test_name = "reset_state";
    data_t    ref_mem [16];
    data_t    mem_model [16];
    amo_rsp_t exp_rsp_q [$];
    mem_req_t exp_wr_q [$];

    amo_adapter u_amo_adapter (.*);

    always #4 clk_i = ~clk_i;

    // Reference model applied in request order to its own memory copy
    task automatic model_request(input amo_req_t r);
        amo_rsp_t rsp;
        mem_req_t wr;
        data_t    old;
        rsp.id = r.id;
        if (r.op > AMO_UMIN || r.addr[1:0] != 2'b00
                || (r.kind == KIND_STORE && r.op == AMO_SWAP)) begin
            rsp.err  = 1'b1;
            rsp.data = ERR_DATA;
        end else begin
            old     = ref_mem[r.addr[5:2]];
            wr.we   = 1'b1;
            wr.addr = r.addr;
            case (r.op)
                AMO_SWAP: wr.wdata = r.operand;
                AMO_ADD:  wr.wdata = old + r.operand;
                AMO_CLR:  wr.wdata = old & ~r.operand;
                AMO_EOR:  wr.wdata = old ^ r.operand;
                AMO_SET:  wr.wdata = old | r.operand;
                AMO_SMAX: wr.wdata = ($signed(old) > $signed(r.operand)) ? old : r.operand;
                AMO_SMIN: wr.wdata = ($signed(old) > $signed(r.operand)) ? r.operand : old;
                AMO_UMAX: wr.wdata = (old > r.operand) ? old : r.operand;
                // Unsigned min is the only code left here
                default:  wr.wdata = (old > r.operand) ? r.operand : old;
            endcase
            ref_mem[r.addr[5:2]] = wr.wdata;
            exp_wr_q.push_back(wr);
            rsp.err  = 1'b0;
            rsp.data = (r.kind == KIND_LOAD) ? old : '0;
        end
        exp_rsp_q.push_back(rsp);
    endtask

    task automatic check_rsp(input string name, input amo_rsp_t exp, input amo_rsp_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected rsp %h, actual rsp %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected mem write %h, actual mem write %h", name, exp, act);
            err_count++;
        end
    endtask

    // Holds valid and data until the decoder takes the request
    task automatic send_req(input amo_req_t r);
        model_request(r);
        if ($unsigned($random(seed)) % 4 == 0) begin
            @(negedge clk_i);
            req_valid_i = 1'b0;
        end
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_i       = r;
        #1;
        while (!req_ready_o) begin
            @(negedge clk_i);
            #1;
        end
    endtask

    // Words limits the address spread, bad_pct the share of invalid requests
    task automatic run_test(input string name, input int count, input int words,
                            input int bad_pct);
        amo_req_t r;
        int       bad;
        int       err_start;
        test_name = name;
        err_start = err_count;
        for (int i = 0; i < count; i++) begin
            r.id      = id_t'(i);
            r.kind    = amo_kind_e'($unsigned($random(seed)) % 2);
            r.op      = amo_op_e'($unsigned($random(seed)) % 9);
            r.addr    = addr_t'(($unsigned($random(seed)) % words) * 4);
            r.operand = $random(seed);
            bad       = $unsigned($random(seed)) % 100;
            if (bad < bad_pct / 2) begin
                r.op = amo_op_e'(9 + $unsigned($random(seed)) % 7);
            end else if (bad < bad_pct) begin
                r.addr[1:0] = 2'(1 + $unsigned($random(seed)) % 3);
            end
            send_req(r);
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
        while (exp_rsp_q.size() != 0) begin
            @(negedge clk_i);
        end
        if (exp_wr_q.size() != 0) begin
            $display("ERROR %s: %0d memory writes were never issued", name, exp_wr_q.size());
            err_count++;
        end
        $display("Test %s done: %0d requests, %0d errors", name, count, err_count - err_start);
    endtask

    // The oldest unanswered request is the one the engine works on
    task automatic serve_mem(input mem_req_t m);
        if (exp_rsp_q.size() == 0 || exp_rsp_q[0].err) begin
            $display("ERROR %s: memory request with no valid atomic in the engine", test_name);
            err_count++;
        end else if (!m.we) begin
            mem_rdata_i = mem_model[m.addr[5:2]];
            rd_delay    = 1 + $unsigned($random(seed)) % 4;
        end else begin
            check_mem(test_name, exp_wr_q.pop_front(), m);
            mem_model[m.addr[5:2]] = m.wdata;
        end
    endtask

    // Memory and response side stall at random
    always begin
        @(negedge clk_i);
        mem_req_ready_i = ($unsigned($random(seed)) % 4) != 0;
        rsp_ready_i     = ($unsigned($random(seed)) % 4) != 0;
        mem_rvalid_i    = 1'b0;
        if (rd_delay > 0) begin
            rd_delay--;
            mem_rvalid_i = (rd_delay == 0);
        end
        #1;
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            serve_mem(mem_req_o);
        end
        if (rst_ni && rsp_valid_o && rsp_ready_i) begin
            n_rsp++;
            if (exp_rsp_q.size() == 0) begin
                $display("ERROR %s: response with no request outstanding", test_name);
                err_count++;
            end else begin
                check_rsp(test_name, exp_rsp_q.pop_front(), rsp_o);
            end
        end
    end

    initial begin
        // Fill pattern spread over the whole word index
        for (int i = 0; i < 16; i++) begin
            ref_mem[i]   = (32'h9e37_79b1 * (i + 1)) ^ 32'h5a5a_0f0f;
            mem_model[i] = ref_mem[i];
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        if (rsp_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            $display("ERROR reset_state: outputs are not idle after reset");
            err_count++;
        end
        $display("Test reset_state done: %0d errors", err_count);
        run_test("same_word", N_SAME, 1, 0);
        run_test("invalid_mix", N_INVALID, 4, 80);
        run_test("random_mix", N_RANDOM, 16, 15);
        $display("Summary: %0d responses checked, %0d errors", n_rsp, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Each request gets 40 cycles
    initial begin
        repeat (N_TOTAL * 40) @(posedge clk_i);
        $display("Timeout: responses still missing after %0d cycles", N_TOTAL * 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
common/amo_pkg.sv
hw/amo_engine/amo_alu.sv
hw/amo_engine/amo_engine.sv
hw/amo_decoder.sv
hw/amo_req_fifo.sv
hw/amo_adapter.sv
tb/amo_adapter_properties.sv
tb/amo_adapter_tb.sv
